//--- rv_isa_pkg.sv
package rv_isa_pkg;

	// Architectural register index, x0 to x31
	typedef logic [4:0] reg_index_t;

	// Instruction format classes of the base set
	typedef enum logic [3:0] {
		CLASS_R,
		CLASS_I,
		CLASS_S,
		CLASS_B,
		CLASS_U,
		CLASS_J,
		CLASS_JALR,
		CLASS_SYSTEM,
		CLASS_OTHER
	} inst_class_t;

	// Major opcodes, bits 6:0
	localparam logic [6:0] OPC_LUI      = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
	localparam logic [6:0] OPC_JAL      = 7'b1101111;
	localparam logic [6:0] OPC_JALR     = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
	localparam logic [6:0] OPC_LOAD     = 7'b0000011;
	localparam logic [6:0] OPC_STORE    = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
	localparam logic [6:0] OPC_OP       = 7'b0110011;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
	localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

	// Complete encodings of the privileged words the fetch unit stops on
	localparam logic [31:0] INST_ECALL = 32'h0000_0073;
	localparam logic [31:0] INST_WFI   = 32'h1050_0073;
	localparam logic [31:0] INST_MRET  = 32'h3020_0073;

endpackage

//--- fetch_pkg.sv
package fetch_pkg;

	// Instruction or data word
	typedef logic [31:0] word_t;

	// Byte address
	typedef logic [31:0] addr_t;

	// Sequencer states
	typedef enum logic [1:0] {
		WAIT_ICACHE,
		WAIT_JUMP,
		WAIT_IRQ
	} fetch_state_t;

	// Defaults for the top level parameters
	localparam addr_t DEFAULT_RESET_VECTOR = 32'h0000_0000;

	// Both must be powers of two
	localparam int unsigned DEFAULT_ICACHE_LINES = 16;
	localparam int unsigned DEFAULT_BHT_ENTRIES  = 32;

endpackage

//--- fetch_predecode.sv
`timescale 1ns/1ps

module fetch_predecode (
	input  fetch_pkg::word_t          i_instruction,
	output rv_isa_pkg::inst_class_t   o_class,
	output logic                      o_is_jump,
	output logic                      o_is_branch,
	output logic                      o_is_mret,
	output logic                      o_is_wait,
	output fetch_pkg::addr_t          o_b_imm,
	output fetch_pkg::addr_t          o_j_imm,
	output rv_isa_pkg::reg_index_t    o_rs1,
	output rv_isa_pkg::reg_index_t    o_rs2,
	output rv_isa_pkg::reg_index_t    o_rs3,
	output rv_isa_pkg::reg_index_t    o_rd
);
	import fetch_pkg::*;
	import rv_isa_pkg::*;

	inst_class_t inst_class;
	logic uses_rs1;
	logic uses_rs2;
	logic uses_rd;

	// Opcode to format class
	always_comb begin
		case (i_instruction[6:0])
			OPC_LUI, OPC_AUIPC:  inst_class = CLASS_U;
			OPC_JAL:             inst_class = CLASS_J;
			OPC_JALR:            inst_class = CLASS_JALR;
			OPC_BRANCH:          inst_class = CLASS_B;
			OPC_LOAD, OPC_OP_IMM: inst_class = CLASS_I;
			OPC_STORE:           inst_class = CLASS_S;
			OPC_OP:              inst_class = CLASS_R;
			OPC_SYSTEM:          inst_class = CLASS_SYSTEM;
			default:             inst_class = CLASS_OTHER;
		endcase
	end

	// Which register fields carry a register for this class
	// SYSTEM counts as CSR access, which reads rs1 and writes rd
	assign uses_rs1 = inst_class inside {CLASS_R, CLASS_I, CLASS_S, CLASS_B, CLASS_JALR,
		CLASS_SYSTEM};
	assign uses_rs2 = inst_class inside {CLASS_R, CLASS_S, CLASS_B};
	assign uses_rd  = inst_class inside {CLASS_R, CLASS_I, CLASS_U, CLASS_J, CLASS_JALR,
		CLASS_SYSTEM};

	assign o_rs1 = uses_rs1 ? i_instruction[19:15] : '0;
	assign o_rs2 = uses_rs2 ? i_instruction[24:20] : '0;
	assign o_rd  = uses_rd  ? i_instruction[11:7]  : '0;
	// No R4 formats in the base set
	assign o_rs3 = '0;

	assign o_b_imm = {{20{i_instruction[31]}}, i_instruction[7], i_instruction[30:25],
		i_instruction[11:8], 1'b0};
	assign o_j_imm = {{12{i_instruction[31]}}, i_instruction[19:12], i_instruction[20],
		i_instruction[30:21], 1'b0};

	assign o_class     = inst_class;
	assign o_is_jump   = (inst_class == CLASS_J) || (inst_class == CLASS_JALR);
	assign o_is_branch = (inst_class == CLASS_B);
	assign o_is_mret   = (i_instruction == INST_MRET);
	assign o_is_wait   = (i_instruction == INST_ECALL) || (i_instruction == INST_WFI);

endmodule

//--- fetch_icache.sv
`timescale 1ns/1ps

module fetch_icache #(
	parameter int unsigned ICACHE_LINES = 16
) (
	input  logic              i_clock,
	input  logic              i_reset,
	input  fetch_pkg::addr_t  i_pc,
	output fetch_pkg::word_t  o_rdata,
	output logic              o_ready,
	output logic              o_bus_request,
	input  logic              i_bus_ready,
	output fetch_pkg::addr_t  o_bus_address,
	input  fetch_pkg::word_t  i_bus_rdata
);
	import fetch_pkg::*;

	localparam int INDEX_BITS = $clog2(ICACHE_LINES);
	localparam int TAG_BITS   = 32 - INDEX_BITS - 2;

	word_t                 line_data [ICACHE_LINES];
	logic [TAG_BITS-1:0]   line_tag [ICACHE_LINES];
	logic [ICACHE_LINES-1:0] line_valid;

	logic [INDEX_BITS-1:0] lookup_index;
	logic [TAG_BITS-1:0]   lookup_tag;
	logic [INDEX_BITS-1:0] fill_index;
	logic [TAG_BITS-1:0]   fill_tag;
	logic                  hit;
	logic                  fill_done;

	assign lookup_index = i_pc[INDEX_BITS+1:2];
	assign lookup_tag   = i_pc[31:INDEX_BITS+2];

	// The fill targets the held bus address, not the current pc
	assign fill_index = o_bus_address[INDEX_BITS+1:2];
	assign fill_tag   = o_bus_address[31:INDEX_BITS+2];
	assign fill_done  = o_bus_request && i_bus_ready;

	assign hit     = line_valid[lookup_index] && (line_tag[lookup_index] == lookup_tag);
	assign o_ready = hit;
	assign o_rdata = line_data[lookup_index];

	// Request and valid bits
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_bus_request <= 1'b0;
			line_valid    <= '0;
		end else if (o_bus_request) begin
			if (i_bus_ready) begin
				o_bus_request          <= 1'b0;
				line_valid[fill_index] <= 1'b1;
			end
		end else if (!hit) begin
			o_bus_request <= 1'b1;
		end
	end

	// Miss address is latched once and held for the whole transfer
	always_ff @(posedge i_clock) begin
		if (!o_bus_request && !hit) begin
			o_bus_address <= i_pc;
		end
		if (fill_done) begin
			line_data[fill_index] <= i_bus_rdata;
			line_tag[fill_index]  <= fill_tag;
		end
	end

endmodule

//--- branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
	parameter int unsigned BHT_ENTRIES = 32
) (
	input  logic              i_clock,
	input  logic              i_reset,
	input  fetch_pkg::addr_t  i_pc,
	input  logic              i_is_jal,
	input  logic              i_is_branch,
	input  fetch_pkg::addr_t  i_b_imm,
	input  fetch_pkg::addr_t  i_j_imm,
	input  fetch_pkg::addr_t  i_pc_launch,
	input  logic              i_jump,
	input  fetch_pkg::addr_t  i_jump_pc,
	output fetch_pkg::addr_t  o_pc_hint
);
	import fetch_pkg::*;

	localparam int BHT_BITS = $clog2(BHT_ENTRIES);

	logic [1:0]          counters [BHT_ENTRIES];
	logic [BHT_BITS-1:0] lookup_index;
	logic [BHT_BITS-1:0] launch_index;
	logic                predict_taken;
	logic                resolved_taken;

	assign lookup_index  = i_pc[BHT_BITS+1:2];
	assign launch_index  = i_pc_launch[BHT_BITS+1:2];
	assign predict_taken = counters[lookup_index][1];

	// Anything other than fall-through counts as taken
	assign resolved_taken = (i_jump_pc != i_pc_launch + 32'd4);

	always_comb begin
		if (i_is_jal)
			o_pc_hint = i_pc + i_j_imm;
		else if (i_is_branch && predict_taken)
			o_pc_hint = i_pc + i_b_imm;
		else
			o_pc_hint = i_pc + 32'd4;
	end

	// Saturating update, start weakly not taken
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 0; i < BHT_ENTRIES; i++)
				counters[i] <= 2'd1;
		end else if (i_jump) begin
			if (resolved_taken && counters[launch_index] != 2'd3)
				counters[launch_index] <= counters[launch_index] + 2'd1;
			else if (!resolved_taken && counters[launch_index] != 2'd0)
				counters[launch_index] <= counters[launch_index] - 2'd1;
		end
	end

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter fetch_pkg::addr_t RESET_VECTOR = 32'h0000_0000,
	parameter int unsigned      ICACHE_LINES = 16,
	parameter int unsigned      BHT_ENTRIES  = 32
) (
	input  logic                    i_clock,
	input  logic                    i_reset,
	output logic                    o_bus_request,
	input  logic                    i_bus_ready,
	output fetch_pkg::addr_t        o_bus_address,
	input  fetch_pkg::word_t        i_bus_rdata,
	input  logic                    i_jump,
	input  fetch_pkg::addr_t        i_jump_pc,
	input  logic                    i_irq_pending,
	input  fetch_pkg::addr_t        i_irq_pc,
	output logic                    o_irq_dispatched,
	output fetch_pkg::addr_t        o_irq_epc,
	input  logic                    i_busy,
	output logic                    o_fetch_strobe,
	output fetch_pkg::addr_t        o_fetch_pc,
	output fetch_pkg::word_t        o_fetch_instruction,
	output rv_isa_pkg::reg_index_t  o_fetch_rs1,
	output rv_isa_pkg::reg_index_t  o_fetch_rs2,
	output rv_isa_pkg::reg_index_t  o_fetch_rs3,
	output rv_isa_pkg::reg_index_t  o_fetch_rd
);
	import fetch_pkg::*;
	import rv_isa_pkg::*;

	fetch_state_t state;
	addr_t        pc;
	addr_t        pc_launch;
	logic         irq_pending_r;

	word_t        icache_rdata;
	logic         icache_ready;

	inst_class_t  pd_class;
	logic         pd_is_jump;
	logic         pd_is_branch;
	logic         pd_is_mret;
	logic         pd_is_wait;
	addr_t        pd_b_imm;
	addr_t        pd_j_imm;
	reg_index_t   pd_rs1;
	reg_index_t   pd_rs2;
	reg_index_t   pd_rs3;
	reg_index_t   pd_rd;

	addr_t        pc_hint;
	logic         irq_edge;
	logic         irq_take;
	logic         deliver;
	logic         needs_jump;

	fetch_icache #(
		.ICACHE_LINES(ICACHE_LINES)
	) u_icache (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_pc          (pc),
		.o_rdata       (icache_rdata),
		.o_ready       (icache_ready),
		.o_bus_request (o_bus_request),
		.i_bus_ready   (i_bus_ready),
		.o_bus_address (o_bus_address),
		.i_bus_rdata   (i_bus_rdata)
	);

	fetch_predecode u_predecode (
		.i_instruction (icache_rdata),
		.o_class       (pd_class),
		.o_is_jump     (pd_is_jump),
		.o_is_branch   (pd_is_branch),
		.o_is_mret     (pd_is_mret),
		.o_is_wait     (pd_is_wait),
		.o_b_imm       (pd_b_imm),
		.o_j_imm       (pd_j_imm),
		.o_rs1         (pd_rs1),
		.o_rs2         (pd_rs2),
		.o_rs3         (pd_rs3),
		.o_rd          (pd_rd)
	);

	branch_predictor #(
		.BHT_ENTRIES(BHT_ENTRIES)
	) u_predictor (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_pc        (pc),
		.i_is_jal    (pd_class == CLASS_J),
		.i_is_branch (pd_is_branch),
		.i_b_imm     (pd_b_imm),
		.i_j_imm     (pd_j_imm),
		.i_pc_launch (pc_launch),
		.i_jump      (i_jump),
		.i_jump_pc   (i_jump_pc),
		.o_pc_hint   (pc_hint)
	);

	// Edge tracking runs in every state so a level raised in WAIT_JUMP is not seen later
	assign irq_edge   = i_irq_pending && !irq_pending_r;
	assign irq_take   = irq_edge && (state == WAIT_ICACHE || state == WAIT_IRQ);
	assign deliver    = (state == WAIT_ICACHE) && !irq_edge && !i_busy && icache_ready;
	assign needs_jump = pd_is_jump || pd_is_branch || pd_is_mret;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state            <= WAIT_ICACHE;
			pc               <= RESET_VECTOR;
			irq_pending_r    <= 1'b0;
			o_irq_dispatched <= 1'b0;
			o_fetch_strobe   <= 1'b0;
		end else begin
			irq_pending_r    <= i_irq_pending;
			o_irq_dispatched <= irq_take;
			case (state)
				WAIT_ICACHE: begin
					if (irq_take) begin
						pc <= i_irq_pc;
					end else if (deliver) begin
						o_fetch_strobe <= ~o_fetch_strobe;
						if (needs_jump) begin
							// Park on the guess so the cache can prefetch it
							pc    <= pc_hint;
							state <= WAIT_JUMP;
						end else if (pd_is_wait) begin
							state <= WAIT_IRQ;
						end else begin
							pc <= pc + 32'd4;
						end
					end
				end
				WAIT_JUMP: begin
					if (i_jump) begin
						pc    <= i_jump_pc;
						state <= WAIT_ICACHE;
					end
				end
				WAIT_IRQ: begin
					if (irq_take) begin
						pc    <= i_irq_pc;
						state <= WAIT_ICACHE;
					end
				end
				default: state <= WAIT_ICACHE;
			endcase
		end
	end

	// Output payload, launch pc and return address
	always_ff @(posedge i_clock) begin
		if (deliver) begin
			o_fetch_pc          <= pc;
			o_fetch_instruction <= icache_rdata;
			o_fetch_rs1         <= pd_rs1;
			o_fetch_rs2         <= pd_rs2;
			o_fetch_rs3         <= pd_rs3;
			o_fetch_rd          <= pd_rd;
			if (needs_jump)
				pc_launch <= pc;
		end
		if (irq_take)
			o_irq_epc <= pc;
	end

endmodule

//--- fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
	parameter fetch_pkg::addr_t RESET_VECTOR = fetch_pkg::DEFAULT_RESET_VECTOR,
	parameter int unsigned      ICACHE_LINES = fetch_pkg::DEFAULT_ICACHE_LINES,
	parameter int unsigned      BHT_ENTRIES  = fetch_pkg::DEFAULT_BHT_ENTRIES
) (
	input  logic                    i_clock,
	input  logic                    i_reset,
	output logic                    o_bus_request,
	input  logic                    i_bus_ready,
	output fetch_pkg::addr_t        o_bus_address,
	input  fetch_pkg::word_t        i_bus_rdata,
	input  logic                    i_jump,
	input  fetch_pkg::addr_t        i_jump_pc,
	input  logic                    i_irq_pending,
	input  fetch_pkg::addr_t        i_irq_pc,
	output logic                    o_irq_dispatched,
	output fetch_pkg::addr_t        o_irq_epc,
	input  logic                    i_busy,
	output logic                    o_fetch_strobe,
	output fetch_pkg::addr_t        o_fetch_pc,
	output fetch_pkg::word_t        o_fetch_instruction,
	output rv_isa_pkg::reg_index_t  o_fetch_rs1,
	output rv_isa_pkg::reg_index_t  o_fetch_rs2,
	output rv_isa_pkg::reg_index_t  o_fetch_rs3,
	output rv_isa_pkg::reg_index_t  o_fetch_rd
);

	fetch_unit #(
		.RESET_VECTOR (RESET_VECTOR),
		.ICACHE_LINES (ICACHE_LINES),
		.BHT_ENTRIES  (BHT_ENTRIES)
	) u_fetch (
		.i_clock             (i_clock),
		.i_reset             (i_reset),
		.o_bus_request       (o_bus_request),
		.i_bus_ready         (i_bus_ready),
		.o_bus_address       (o_bus_address),
		.i_bus_rdata         (i_bus_rdata),
		.i_jump              (i_jump),
		.i_jump_pc           (i_jump_pc),
		.i_irq_pending       (i_irq_pending),
		.i_irq_pc            (i_irq_pc),
		.o_irq_dispatched    (o_irq_dispatched),
		.o_irq_epc           (o_irq_epc),
		.i_busy              (i_busy),
		.o_fetch_strobe      (o_fetch_strobe),
		.o_fetch_pc          (o_fetch_pc),
		.o_fetch_instruction (o_fetch_instruction),
		.o_fetch_rs1         (o_fetch_rs1),
		.o_fetch_rs2         (o_fetch_rs2),
		.o_fetch_rs3         (o_fetch_rs3),
		.o_fetch_rd          (o_fetch_rd)
	);

endmodule

//--- fetch_props.sv
`timescale 1ns/1ps

module fetch_props (
	input logic                    i_clock,
	input logic                    i_reset,
	input logic                    o_bus_request,
	input logic                    i_bus_ready,
	input fetch_pkg::addr_t        o_bus_address,
	input logic                    o_fetch_strobe,
	input logic                    i_busy,
	input logic                    o_irq_dispatched,
	input fetch_pkg::fetch_state_t state
);
	import fetch_pkg::*;

	// Miss address held for the whole transfer
	bus_address_held: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=> $stable(o_bus_address))
		else $error("bus address changed while a request was waiting");

	// Back-pressure freezes the output
	no_strobe_when_busy: assert property (@(posedge i_clock) disable iff (i_reset)
		$changed(o_fetch_strobe) |-> !$past(i_busy) && $past(state) == WAIT_ICACHE)
		else $error("fetch strobe toggled while busy or outside WAIT_ICACHE");

	irq_pulse_single: assert property (@(posedge i_clock) disable iff (i_reset)
		o_irq_dispatched |=> !o_irq_dispatched)
		else $error("irq dispatch pulse lasted two cycles");

endmodule

bind fetch_unit fetch_props u_props (
	.i_clock          (i_clock),
	.i_reset          (i_reset),
	.o_bus_request    (o_bus_request),
	.i_bus_ready      (i_bus_ready),
	.o_bus_address    (o_bus_address),
	.o_fetch_strobe   (o_fetch_strobe),
	.i_busy           (i_busy),
	.o_irq_dispatched (o_irq_dispatched),
	.state            (state)
);

//--- tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;
	import fetch_pkg::*;
	import rv_isa_pkg::*;

	localparam int TIMEOUT = 200;

	logic clock, reset, bus_ready, jump, irq_pending, busy;
	logic bus_request, irq_dispatched, fetch_strobe;
	addr_t bus_address, jump_pc, irq_pc, irq_epc, fetch_pc;
	word_t bus_rdata, fetch_instruction;
	reg_index_t fetch_rs1, fetch_rs2, fetch_rs3, fetch_rd;

	word_t mem [256];
	logic [83:0] deliveries [$];
	logic strobe_seen;
	logic hit_window;
	logic busy_random;
	int bus_wait;
	int hit_misses;
	int errors, tests_run, tests_failed, errors_at_start;
	integer seed = 32'h7057_f09f;
	addr_t exp_pc;

	fetch_top #(
		.RESET_VECTOR (DEFAULT_RESET_VECTOR),
		.ICACHE_LINES (DEFAULT_ICACHE_LINES),
		.BHT_ENTRIES  (DEFAULT_BHT_ENTRIES)
	) DUT (
		.i_clock (clock), .i_reset (reset),
		.o_bus_request (bus_request), .i_bus_ready (bus_ready),
		.o_bus_address (bus_address), .i_bus_rdata (bus_rdata),
		.i_jump (jump), .i_jump_pc (jump_pc),
		.i_irq_pending (irq_pending), .i_irq_pc (irq_pc),
		.o_irq_dispatched (irq_dispatched), .o_irq_epc (irq_epc),
		.i_busy (busy), .o_fetch_strobe (fetch_strobe), .o_fetch_pc (fetch_pc),
		.o_fetch_instruction (fetch_instruction),
		.o_fetch_rs1 (fetch_rs1), .o_fetch_rs2 (fetch_rs2),
		.o_fetch_rs3 (fetch_rs3), .o_fetch_rd (fetch_rd)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Expected {rs1, rs2, rs3, rd} with each field kept only where the format has it
	function automatic logic [19:0] ref_decode(input word_t w);
		logic r1, r2, rd;
		r1 = w[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JALR,
			OPC_SYSTEM};
		r2 = w[6:0] inside {OPC_OP, OPC_STORE, OPC_BRANCH};
		rd = w[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_LUI, OPC_AUIPC, OPC_JAL,
			OPC_JALR, OPC_SYSTEM};
		return {r1 ? w[19:15] : 5'd0, r2 ? w[24:20] : 5'd0, 5'd0, rd ? w[11:7] : 5'd0};
	endfunction

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (exp !== act) begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_reg(input string name, input reg_index_t exp, input reg_index_t act);
		if (exp !== act) begin
			$display("mismatch %s: expected x%0d, actual x%0d", name, exp, act);
			errors++;
		end
	endtask

	// Behavioral memory that answers after a random delay
	always @(negedge clock) begin
		if (bus_ready) begin
			bus_ready = 1'b0;
		end else if (bus_request) begin
			if (bus_wait == 0)
				bus_wait = 1 + ({$random(seed)} % 4);
			bus_wait--;
			if (bus_wait == 0) begin
				bus_ready = 1'b1;
				bus_rdata = mem[bus_address[9:2]];
			end
		end
		busy = busy_random ? $random(seed) & 1 : 1'b0;
	end

	// Every strobe toggle goes into the queue
	always @(negedge clock) begin
		if (!reset && fetch_strobe !== strobe_seen) begin
			strobe_seen = fetch_strobe;
			deliveries.push_back({fetch_pc, fetch_instruction, fetch_rs1, fetch_rs2,
				fetch_rs3, fetch_rd});
		end
		if (hit_window && bus_request)
			hit_misses++;
	end

	task automatic expect_delivery(input string name, input addr_t pc);
		int waited;
		logic [83:0] d;
		logic [19:0] regs;
		waited = 0;
		while (deliveries.size() == 0 && waited < TIMEOUT) begin
			@(negedge clock);
			waited++;
		end
		if (deliveries.size() == 0) begin
			$display("%s: no instruction delivered for pc %h before timeout", name, pc);
			errors++;
		end else begin
			d = deliveries.pop_front();
			regs = ref_decode(mem[pc[9:2]]);
			check_addr({name, " pc"}, pc, d[83:52]);
			check_word({name, " instruction"}, mem[pc[9:2]], d[51:20]);
			check_reg({name, " rs1"}, regs[19:15], d[19:15]);
			check_reg({name, " rs2"}, regs[14:10], d[14:10]);
			check_reg({name, " rs3"}, regs[9:5], d[9:5]);
			check_reg({name, " rd"}, regs[4:0], d[4:0]);
		end
	endtask

	task automatic expect_quiet(input string name, input int cycles);
		repeat (cycles) @(negedge clock);
		if (deliveries.size() != 0) begin
			$display("%s: instruction delivered while fetch should be stopped", name);
			errors++;
			deliveries.delete();
		end
	endtask

	task automatic pulse_jump(input addr_t target);
		@(negedge clock);
		jump = 1'b1;
		jump_pc = target;
		@(negedge clock);
		jump = 1'b0;
	endtask

	task automatic raise_irq(input string name, input addr_t target);
		int waited;
		@(negedge clock);
		irq_pending = 1'b1;
		irq_pc = target;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
		end while (!irq_dispatched && waited < TIMEOUT);
		if (!irq_dispatched) begin
			$display("%s: interrupt was never dispatched", name);
			errors++;
		end
		irq_pending = 1'b0;
	endtask

	task automatic start_test();
		errors_at_start = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != errors_at_start)
			tests_failed++;
		$display("test %s: %s", name, errors == errors_at_start ? "ok" : "failed");
	endtask

	initial begin
		// Fill with ADDI words whose fields come from the address
		for (int i = 0; i < 256; i++)
			mem[i] = {i[11:0], i[4:0], 3'b000, 5'(i + 1), OPC_OP_IMM};
		mem[32'h10 >> 2]  = INST_ECALL;
		mem[32'h44 >> 2]  = 32'h0020_8863;
		mem[32'h8c >> 2]  = 32'hff5f_f06f;
		mem[32'h134 >> 2] = INST_WFI;
		mem[32'h180 >> 2] = INST_MRET;
		{reset, bus_ready, jump, irq_pending, busy} = 5'b10000;
		{jump_pc, irq_pc, bus_rdata} = '0;
		{strobe_seen, hit_window, busy_random} = 3'b000;
		{bus_wait, hit_misses, errors, tests_run, tests_failed} = '0;
		repeat (4) @(negedge clock);
		reset = 1'b0;

		start_test();
		for (int i = 0; i < 4; i++)
			expect_delivery("sequential", DEFAULT_RESET_VECTOR + 4 * i);
		end_test("sequential");

		start_test();
		expect_delivery("ecall", 32'h10);
		expect_quiet("ecall", 12);
		raise_irq("ecall", 32'h40);
		check_addr("ecall epc", 32'h10, irq_epc);
		expect_delivery("ecall", 32'h40);
		end_test("ecall");

		start_test();
		expect_delivery("branch", 32'h44);
		expect_quiet("branch", 12);
		pulse_jump(32'h80);
		for (int i = 0; i < 4; i++)
			expect_delivery("branch", 32'h80 + 4 * i);
		end_test("branch");

		// Second pass through the loop must hit in the cache
		start_test();
		expect_quiet("cache hit", 12);
		hit_window = 1'b1;
		pulse_jump(32'h80);
		for (int i = 0; i < 4; i++)
			expect_delivery("cache hit", 32'h80 + 4 * i);
		hit_window = 1'b0;
		if (hit_misses != 0) begin
			$display("cache hit: bus request raised during the second loop pass");
			errors++;
		end
		end_test("cache hit");

		start_test();
		pulse_jump(32'h180);
		expect_delivery("mret", 32'h180);
		expect_quiet("mret", 12);
		pulse_jump(32'hc0);
		end_test("mret");

		start_test();
		expect_delivery("irq in fetch", 32'hc0);
		expect_delivery("irq in fetch", 32'hc4);
		raise_irq("irq in fetch", 32'h100);
		exp_pc = 32'hc8;
		while (deliveries.size() != 0) begin
			expect_delivery("irq in fetch", exp_pc);
			exp_pc += 4;
		end
		check_addr("irq in fetch epc", exp_pc, irq_epc);
		expect_delivery("irq in fetch", 32'h100);
		end_test("irq in fetch");

		start_test();
		busy_random = 1'b1;
		for (int i = 1; i < 13; i++)
			expect_delivery("back-pressure", 32'h100 + 4 * i);
		busy_random = 1'b0;
		end_test("back-pressure");

		// WFI stops fetch the same way as ECALL
		start_test();
		expect_delivery("wfi", 32'h134);
		expect_quiet("wfi", 12);
		raise_irq("wfi", 32'h1c0);
		check_addr("wfi epc", 32'h134, irq_epc);
		expect_delivery("wfi", 32'h1c0);
		end_test("wfi");

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- list.f
rv_isa_pkg.sv
fetch_pkg.sv
fetch_predecode.sv
fetch_icache.sv
branch_predictor.sv
fetch_unit.sv
fetch_top.sv
fetch_props.sv
tb_fetch.sv
